//--- Makefile
VERILATOR  ?= verilator
FILELIST   := all.f
TOP        := tb_demo_system
RTL_TOP    := demo_system
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
SIM_BIN    := sim_$(TOP)
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+include
verilog/demo_pkg.sv
verilog/bus_decoder.sv
verilog/ram_1p.sv
verilog/gpio.sv
verilog/timer.sv
verilog/demo_system.sv
bench/bus_monitor.sv
bench/tb_demo_system.sv

//--- bench/bus_monitor.sv
// Host port monitor with RAM, GPIO output and compare register models
// Checks grant, responses, gp_o and timer_irq_o

`timescale 1ns/1ps

`include "demo_defs.svh"

module bus_monitor import demo_pkg::*; (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  logic                   host_req_i,
  input  logic                   host_gnt_i,
  input  bus_req_t               host_req_pkt_i,
  input  bus_rsp_t               host_rsp_i,
  input  logic [`DEMO_GPI_W-1:0] gp_i,
  input  logic [`DEMO_GPO_W-1:0] gpo_i,
  input  logic                   irq_i,
  input  logic                   irq_chk_i,
  input  logic                   irq_exp_i,
  output int                     data_errs_o,
  output int                     proto_errs_o,
  output int                     pending_o
);

  typedef struct packed {
    logic  chk;     // Compare rdata
    logic  err;
    data_t rdata;
    addr_t addr;
  } exp_rsp_t;

  exp_rsp_t               exp_q[$];
  exp_rsp_t               cur;
  data_t                  ram_model[int];
  logic [`DEMO_GPO_W-1:0] gpo_model;
  data_t                  cmp_model;
  int                     data_errs = 0;
  int                     proto_errs = 0;
  int                     pending = 0;

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t be);
    data_t m;
    for (int b = 0; b < `DEMO_BE_W; b++) begin
      m[b*8 +: 8] = be[b] ? new_w[b*8 +: 8] : old_w[b*8 +: 8];
    end
    return m;
  endfunction

  // Expected response of one granted access with the models updated in order
  task automatic predict_access(input bus_req_t p);
    exp_rsp_t e;
    int       idx;
    int       off;
    data_t    m;
    e   = '{chk: 1'b1, err: 1'b0, rdata: '0, addr: p.addr};
    idx = int'((p.addr - `DEMO_RAM_START) >> 2);
    off = int'(p.addr & (`DEMO_REGION_SIZE - 1));
    if ((p.addr & ~(`DEMO_RAM_SIZE - 1)) == `DEMO_RAM_START) begin
      if (p.we) begin
        m = ram_model.exists(idx) ? ram_model[idx] : '0;
        ram_model[idx] = merge_bytes(m, p.wdata, p.be);
      end else if (ram_model.exists(idx)) e.rdata = ram_model[idx];
      else e.chk = 1'b0;  // Never written
    end else if ((p.addr & ~(`DEMO_REGION_SIZE - 1)) == `DEMO_GPIO_START) begin
      if (p.we && off == 0) begin
        m = merge_bytes(data_t'(gpo_model), p.wdata, p.be);
        gpo_model = m[`DEMO_GPO_W-1:0];
      end else if (!p.we && off == 0) e.rdata = data_t'(gpo_model);
      else if (!p.we && off == 4) e.rdata = data_t'(gp_i);
    end else if ((p.addr & ~(`DEMO_REGION_SIZE - 1)) == `DEMO_TIMER_START) begin
      if (p.we && off == 4) cmp_model = merge_bytes(cmp_model, p.wdata, p.be);
      else if (!p.we && off == 0) e.chk = 1'b0;  // mtime keeps counting
      else if (!p.we && off == 4) e.rdata = cmp_model;
    end else begin
      e.err = 1'b1;
    end
    exp_q.push_back(e);
  endtask

  always @(negedge clk_sys_i) begin
    if (!rst_sys_ni) begin
      exp_q.delete();
      gpo_model = '0;
      cmp_model = '1;
    end else begin
      if (host_rsp_i.rvalid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Error: a response arrived with no access outstanding");
          proto_errs++;
        end else begin
          cur = exp_q.pop_front();
          if (host_rsp_i.err !== cur.err) begin
            $display("FAIL host_rsp_o.err: got %h, expected %h (addr %h)",
                     host_rsp_i.err, cur.err, cur.addr);
            data_errs++;
          end
          if (cur.chk && host_rsp_i.rdata !== cur.rdata) begin
            $display("FAIL host_rsp_o.rdata: got %h, expected %h (addr %h)",
                     host_rsp_i.rdata, cur.rdata, cur.addr);
            data_errs++;
          end
        end
      end else if (exp_q.size() != 0) begin
        cur = exp_q.pop_front();
        $display("Error: no response came back for the access to address %h", cur.addr);
        proto_errs++;
      end
      if (host_gnt_i !== host_req_i) begin  // Every request is granted at once
        $display("FAIL host_gnt_o: got %h, expected %h", host_gnt_i, host_req_i);
        data_errs++;
      end
      if (gpo_i !== gpo_model) begin
        $display("FAIL gp_o: got %h, expected %h", gpo_i, gpo_model);
        data_errs++;
      end
      if (irq_chk_i && irq_i !== irq_exp_i) begin
        $display("FAIL timer_irq_o: got %h, expected %h", irq_i, irq_exp_i);
        data_errs++;
      end
      if (host_gnt_i === 1'b1) predict_access(host_req_pkt_i);
    end
    pending = exp_q.size();
  end

  assign data_errs_o  = data_errs;
  assign proto_errs_o = proto_errs;
  assign pending_o    = pending;

endmodule

//--- bench/tb_demo_system.sv
// Testbench top for the demo system with clock, reset, stimulus table,
// LFSR driven RAM accesses, timeout and final report

`timescale 1ns/1ps

`include "demo_defs.svh"

module tb_demo_system import demo_pkg::*; ();

  localparam int RandPairs = 8;

  typedef struct packed {
    logic                   req;
    logic                   we;
    addr_t                  addr;
    strb_t                  be;
    data_t                  wdata;
    logic [`DEMO_GPI_W-1:0] gpi;
    logic                   irq_chk;
    logic                   irq_exp;
  } stim_t;

  logic                   clk_sys;
  logic                   rst_sys_n;
  logic                   host_req;
  logic                   host_gnt;
  bus_req_t               host_req_pkt;
  bus_rsp_t               host_rsp;
  logic [`DEMO_GPI_W-1:0] gp_in;
  logic [`DEMO_GPO_W-1:0] gp_out;
  logic                   timer_irq;
  logic                   irq_chk;
  logic                   irq_exp;
  stim_t                  stim_q[$];
  logic [`DEMO_GPI_W-1:0] cur_gpi;
  logic [31:0]            lfsr_state;
  int                     data_errs;
  int                     proto_errs;
  int                     pending;
  int                     cycles = 0;
  int                     limit = 1000;

  demo_system dut0 (
    .clk_sys_i      (clk_sys),
    .rst_sys_ni     (rst_sys_n),
    .host_req_i     (host_req),
    .host_gnt_o     (host_gnt),
    .host_req_pkt_i (host_req_pkt),
    .host_rsp_o     (host_rsp),
    .gp_i           (gp_in),
    .gp_o           (gp_out),
    .timer_irq_o    (timer_irq)
  );

  bus_monitor u_mon (
    .clk_sys_i      (clk_sys),
    .rst_sys_ni     (rst_sys_n),
    .host_req_i     (host_req),
    .host_gnt_i     (host_gnt),
    .host_req_pkt_i (host_req_pkt),
    .host_rsp_i     (host_rsp),
    .gp_i           (gp_in),
    .gpo_i          (gp_out),
    .irq_i          (timer_irq),
    .irq_chk_i      (irq_chk),
    .irq_exp_i      (irq_exp),
    .data_errs_o    (data_errs),
    .proto_errs_o   (proto_errs),
    .pending_o      (pending)
  );

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic push_entry(input logic req, input logic we, input addr_t addr,
                            input strb_t be, input data_t wdata,
                            input logic chk, input logic exp);
    stim_t s;
    s = '{req: req, we: we, addr: addr, be: be, wdata: wdata,
          gpi: cur_gpi, irq_chk: chk, irq_exp: exp};
    stim_q.push_back(s);
  endtask

  task automatic wr_access(input addr_t a, input strb_t be, input data_t d);
    push_entry(1'b1, 1'b1, a, be, d, 1'b0, 1'b0);
  endtask

  task automatic rd_access(input addr_t a);
    push_entry(1'b1, 1'b0, a, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic irq_probe(input logic exp);  // mtimecmp read plus interrupt check
    push_entry(1'b1, 1'b0, `DEMO_TIMER_START + 32'h4, '0, '0, 1'b1, exp);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) push_entry(1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic build_table();
    addr_t ra[RandPairs];
    irq_probe(1'b0);                                   // Straight out of reset
    wr_access(32'h0010_0000, 4'hf, 32'hdead_beef);
    wr_access(32'h0010_0004, 4'hf, 32'h1234_5678);
    wr_access(32'h0010_0ffc, 4'hf, 32'ha5a5_5a5a);
    rd_access(32'h0010_0000);                          // Back to back reads
    rd_access(32'h0010_0004);
    rd_access(32'h0010_0ffc);
    wr_access(32'h0010_0008, 4'hf, 32'h1122_3344);
    wr_access(32'h0010_0008, 4'b0101, 32'haabb_ccdd);
    rd_access(32'h0010_0008);
    wr_access(`DEMO_GPIO_START, 4'b0011, 32'h0000_1234);
    wr_access(`DEMO_GPIO_START, 4'b0010, 32'h0000_ab00);
    wr_access(`DEMO_GPIO_START, 4'b1100, 32'hffff_0000);  // Above the port width
    rd_access(`DEMO_GPIO_START);
    // Input port held stable through the synchroniser
    cur_gpi = 8'ha7;
    idle_cycles(4);
    rd_access(`DEMO_GPIO_START + 32'h4);
    cur_gpi = 8'h3c;
    idle_cycles(5);
    rd_access(`DEMO_GPIO_START + 32'h4);
    wr_access(`DEMO_GPIO_START + 32'h4, 4'hf, 32'hffff_ffff);
    rd_access(`DEMO_GPIO_START + 32'h8);
    rd_access(32'h4000_0000);                          // Unmapped
    wr_access(32'h4000_0000, 4'hf, 32'h0bad_0bad);
    rd_access(32'h0010_0004);
    wr_access(`DEMO_TIMER_START, 4'hf, 32'h0);
    wr_access(`DEMO_TIMER_START + 32'h4, 4'hf, 32'd40);
    irq_probe(1'b0);
    idle_cycles(48);
    irq_probe(1'b1);
    wr_access(`DEMO_TIMER_START + 32'h4, 4'hf, 32'hffff_ffff);
    idle_cycles(2);
    irq_probe(1'b0);
    rd_access(`DEMO_TIMER_START);
    for (int i = 0; i < RandPairs; i++) begin
      ra[i] = `DEMO_RAM_START + (lfsr_bits(10) << 2);
      wr_access(ra[i], 4'hf, lfsr_bits(32));
    end
    for (int i = 0; i < RandPairs; i++) rd_access(ra[i]);
  endtask

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    stim_t s;
    lfsr_state   = 32'h52fdc392;
    cur_gpi      = '0;
    rst_sys_n    = 1'b0;
    host_req     = 1'b0;
    host_req_pkt = '0;
    gp_in        = '0;
    irq_chk      = 1'b0;
    irq_exp      = 1'b0;
    build_table();
    limit = 4 * stim_q.size() + 300;
    repeat (2) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    foreach (stim_q[i]) begin
      s = stim_q[i];
      @(posedge clk_sys);
      host_req     <= s.req;
      host_req_pkt <= '{addr: s.addr, we: s.we, be: s.be, wdata: s.wdata};
      gp_in        <= s.gpi;
      irq_chk      <= s.irq_chk;
      irq_exp      <= s.irq_exp;
    end
    @(posedge clk_sys);
    host_req <= 1'b0;
    irq_chk  <= 1'b0;
    do @(posedge clk_sys); while (pending != 0);  // Drain responses in flight
    $display("Errors: data %0d, protocol %0d", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- include/demo_defs.svh
// Bus widths, memory map and reset values of the demo fabric

`ifndef DEMO_DEFS_SVH
`define DEMO_DEFS_SVH

// Bus widths
`define DEMO_DATA_W 32
`define DEMO_ADDR_W 32
`define DEMO_BE_W   4

// RAM region, 4 KiB
`define DEMO_RAM_START 32'h00100000
`define DEMO_RAM_SIZE  32'h00001000

// Peripheral regions, 4 KiB each
`define DEMO_GPIO_START  32'h80000000
`define DEMO_TIMER_START 32'h80002000
`define DEMO_REGION_SIZE 32'h00001000

// Timer reset values
`define DEMO_MTIME_RST     {`DEMO_DATA_W{1'b0}}
`define DEMO_TIMER_CMP_RST {`DEMO_DATA_W{1'b1}}

// GPIO widths and output reset value
`define DEMO_GPO_W   16
`define DEMO_GPI_W   8
`define DEMO_GPO_RST {`DEMO_GPO_W{1'b0}}

`endif

//--- verilog/bus_decoder.sv
// Address decoder for one host and three devices, with the
// registered device select and the error response for unmapped addresses

`timescale 1ns/1ps

`include "demo_defs.svh"

module bus_decoder import demo_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,

  input  logic     host_req_i,
  output logic     host_gnt_o,
  input  bus_req_t host_req_pkt_i,
  output bus_rsp_t host_rsp_o,

  output logic     ram_req_o,
  output logic     gpio_req_o,
  output logic     timer_req_o,
  output bus_req_t dev_req_pkt_o,
  input  dev_rsp_t ram_rsp_i,
  input  dev_rsp_t gpio_rsp_i,
  input  dev_rsp_t timer_rsp_i
);

  localparam addr_t RamMask    = ~(`DEMO_RAM_SIZE - 1);
  localparam addr_t RegionMask = ~(`DEMO_REGION_SIZE - 1);

  dev_sel_e sel;
  dev_sel_e sel_q;    // Device of the access in flight
  logic     pend_q;
  logic     we_q;
  logic     rsp_valid;
  data_t    rsp_rdata;

  always_comb begin
    if ((host_req_pkt_i.addr & RamMask) == `DEMO_RAM_START) begin
      sel = DEV_RAM;
    end else if ((host_req_pkt_i.addr & RegionMask) == `DEMO_GPIO_START) begin
      sel = DEV_GPIO;
    end else if ((host_req_pkt_i.addr & RegionMask) == `DEMO_TIMER_START) begin
      sel = DEV_TIMER;
    end else begin
      sel = DEV_NONE;
    end
  end

  assign host_gnt_o    = host_req_i;  // No back-pressure
  assign ram_req_o     = host_req_i && (sel == DEV_RAM);
  assign gpio_req_o    = host_req_i && (sel == DEV_GPIO);
  assign timer_req_o   = host_req_i && (sel == DEV_TIMER);
  assign dev_req_pkt_o = host_req_pkt_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pend_q <= 1'b0;
      sel_q  <= DEV_NONE;
      we_q   <= 1'b0;
    end else begin
      pend_q <= host_req_i;
      sel_q  <= sel;
      we_q   <= host_req_pkt_i.we;
    end
  end

  always_comb begin
    unique case (sel_q)
      DEV_RAM:   {rsp_valid, rsp_rdata} = ram_rsp_i;
      DEV_GPIO:  {rsp_valid, rsp_rdata} = gpio_rsp_i;
      DEV_TIMER: {rsp_valid, rsp_rdata} = timer_rsp_i;
      default:   {rsp_valid, rsp_rdata} = {pend_q, {`DEMO_DATA_W{1'b0}}};  // Unmapped
    endcase
  end

  assign host_rsp_o.rvalid = rsp_valid;
  assign host_rsp_o.err    = pend_q && (sel_q == DEV_NONE);
  assign host_rsp_o.rdata  = (rsp_valid && !we_q) ? rsp_rdata : '0;  // Writes read zero

endmodule

//--- verilog/demo_pkg.sv
// Bus vector types, request and response structs, device select
// and the byte-enable merge shared by all writable registers

`include "demo_defs.svh"

package demo_pkg;

  typedef logic [`DEMO_DATA_W-1:0] data_t;
  typedef logic [`DEMO_ADDR_W-1:0] addr_t;
  typedef logic [`DEMO_BE_W-1:0]   strb_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    strb_t be;
    data_t wdata;
  } bus_req_t;

  // Host side response
  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  // Device side response, no error path
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } dev_rsp_t;

  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER,
    DEV_NONE
  } dev_sel_e;

  // Replace the enabled bytes of old_val with those of new_val
  function automatic data_t apply_be(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int i = 0; i < `DEMO_BE_W; i++) begin
      if (be[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

//--- verilog/demo_system.sv
// Demo system top with bus decoder, RAM, GPIO and timer

`timescale 1ns/1ps

`include "demo_defs.svh"

module demo_system import demo_pkg::*; (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  input  logic                   host_req_i,
  output logic                   host_gnt_o,
  input  bus_req_t               host_req_pkt_i,
  output bus_rsp_t               host_rsp_o,

  input  logic [`DEMO_GPI_W-1:0] gp_i,
  output logic [`DEMO_GPO_W-1:0] gp_o,
  output logic                   timer_irq_o
);

  logic     ram_req;
  logic     gpio_req;
  logic     timer_req;
  bus_req_t dev_req_pkt;   // Shared by all devices
  dev_rsp_t ram_rsp;
  dev_rsp_t gpio_rsp;
  dev_rsp_t timer_rsp;

  bus_decoder u_bus (
    .clk_sys_i, .rst_sys_ni,
    .host_req_i, .host_gnt_o, .host_req_pkt_i, .host_rsp_o,
    .ram_req_o     (ram_req),
    .gpio_req_o    (gpio_req),
    .timer_req_o   (timer_req),
    .dev_req_pkt_o (dev_req_pkt),
    .ram_rsp_i     (ram_rsp),
    .gpio_rsp_i    (gpio_rsp),
    .timer_rsp_i   (timer_rsp)
  );

  ram_1p u_ram (
    .clk_sys_i, .rst_sys_ni,
    .req_i (ram_req), .req_pkt_i (dev_req_pkt), .rsp_o (ram_rsp)
  );

  gpio u_gpio (
    .clk_sys_i, .rst_sys_ni,
    .req_i (gpio_req), .req_pkt_i (dev_req_pkt), .rsp_o (gpio_rsp),
    .gp_i, .gp_o
  );

  timer u_timer (
    .clk_sys_i, .rst_sys_ni,
    .req_i (timer_req), .req_pkt_i (dev_req_pkt), .rsp_o (timer_rsp),
    .timer_irq_o
  );

endmodule

//--- verilog/gpio.sv
// GPIO block with a byte-enabled output register
// and a synchronised, readable input port

`timescale 1ns/1ps

`include "demo_defs.svh"

module gpio import demo_pkg::*; (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  logic                   req_i,
  input  bus_req_t               req_pkt_i,
  output dev_rsp_t               rsp_o,
  input  logic [`DEMO_GPI_W-1:0] gp_i,
  output logic [`DEMO_GPO_W-1:0] gp_o
);

  localparam int OffW = $clog2(`DEMO_REGION_SIZE);

  logic [OffW-1:0]        offset;
  logic [`DEMO_GPO_W-1:0] gpo_q;
  logic [`DEMO_GPI_W-1:0] gpi_meta_q;
  logic [`DEMO_GPI_W-1:0] gpi_sync_q;
  data_t                  gpo_wr;
  logic                   rvalid_q;
  data_t                  rdata_q;

  assign offset = req_pkt_i.addr[OffW-1:0];
  assign gpo_wr = apply_be(data_t'(gpo_q), req_pkt_i.wdata, req_pkt_i.be);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= `DEMO_GPO_RST;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;        // Two-flop synchroniser
      gpi_sync_q <= gpi_meta_q;
      rvalid_q   <= req_i;
      if (req_i && req_pkt_i.we && offset == '0) gpo_q <= gpo_wr[`DEMO_GPO_W-1:0];
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !req_pkt_i.we) begin
      if (offset == OffW'(0))      rdata_q <= data_t'(gpo_q);
      else if (offset == OffW'(4)) rdata_q <= data_t'(gpi_sync_q);
      else                         rdata_q <= '0;
    end
  end

  assign gp_o  = gpo_q;
  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

//--- verilog/ram_1p.sv
// Single-port word RAM with byte-enable writes and one-cycle reads

`timescale 1ns/1ps

`include "demo_defs.svh"

module ram_1p import demo_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,
  input  logic     req_i,
  input  bus_req_t req_pkt_i,
  output dev_rsp_t rsp_o
);

  localparam int Depth = `DEMO_RAM_SIZE / 4;
  localparam int IdxW  = $clog2(Depth);

  data_t           mem_q [Depth];
  logic [IdxW-1:0] idx;
  logic            rvalid_q;
  data_t           rdata_q;

  assign idx = req_pkt_i.addr[IdxW+1:2];  // Word index above byte offset

  always_ff @(posedge clk_sys_i) begin
    if (req_i && req_pkt_i.we) begin
      mem_q[idx] <= apply_be(mem_q[idx], req_pkt_i.wdata, req_pkt_i.be);
    end
    if (req_i && !req_pkt_i.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) rvalid_q <= 1'b0;
    else             rvalid_q <= req_i;
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

//--- verilog/timer.sv
// Machine timer with mtime counter, mtimecmp compare register
// and registered interrupt

`timescale 1ns/1ps

`include "demo_defs.svh"

module timer import demo_pkg::*; (
  input  logic     clk_sys_i,
  input  logic     rst_sys_ni,
  input  logic     req_i,
  input  bus_req_t req_pkt_i,
  output dev_rsp_t rsp_o,
  output logic     timer_irq_o
);

  localparam int OffW = $clog2(`DEMO_REGION_SIZE);

  logic [OffW-1:0] offset;
  logic            mtime_we;
  logic            mtimecmp_we;
  data_t           mtime_q;
  data_t           mtimecmp_q;
  logic            irq_q;
  logic            rvalid_q;
  data_t           rdata_q;

  assign offset      = req_pkt_i.addr[OffW-1:0];
  assign mtime_we    = req_i && req_pkt_i.we && (offset == OffW'(0));
  assign mtimecmp_we = req_i && req_pkt_i.we && (offset == OffW'(4));

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= `DEMO_MTIME_RST;
      mtimecmp_q <= `DEMO_TIMER_CMP_RST;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      // Written value takes the place of the increment
      if (mtime_we) mtime_q <= apply_be(mtime_q, req_pkt_i.wdata, req_pkt_i.be);
      else          mtime_q <= mtime_q + 1'b1;

      if (mtimecmp_we) begin
        mtimecmp_q <= apply_be(mtimecmp_q, req_pkt_i.wdata, req_pkt_i.be);
      end

      irq_q    <= (mtime_q >= mtimecmp_q);  // Unsigned compare
      rvalid_q <= req_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !req_pkt_i.we) begin
      if (offset == OffW'(0))      rdata_q <= mtime_q;
      else if (offset == OffW'(4)) rdata_q <= mtimecmp_q;
      else                         rdata_q <= '0;
    end
  end

  assign timer_irq_o = irq_q;
  assign rsp_o       = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule
